// ==== include/advtim_params.svh ====
//==========================================================================
// advanced timer parameters
// widths, APB register map, channel mode codes and interrupt bit positions
//==========================================================================

`ifndef ADVTIM_PARAMS_SVH
`define ADVTIM_PARAMS_SVH

// bus and counter widths
`define ADVTIM_CNT_W		16
`define ADVTIM_ADDR_W		8
`define ADVTIM_DATA_W		32

// register map, byte offsets
`define ADVTIM_REG_CTRL		8'h00
`define ADVTIM_REG_PSC		8'h04
`define ADVTIM_REG_ARR		8'h08
`define ADVTIM_REG_RCR		8'h0C
`define ADVTIM_REG_CH1		8'h10
`define ADVTIM_REG_CH2		8'h14
`define ADVTIM_REG_INT_EN	8'h18
`define ADVTIM_REG_INT_STA	8'h1C
`define ADVTIM_REG_STAT		8'h20

// output compare modes
`define ADVTIM_OC_FRZ_LO	3'd0
`define ADVTIM_OC_FRZ_HI	3'd1
`define ADVTIM_OC_PWM1		3'd6
`define ADVTIM_OC_PWM2		3'd7

// interrupt sources
`define ADVTIM_INT_RELOAD	0
`define ADVTIM_INT_END		1
`define ADVTIM_INT_NUM		2

`endif

// ==== logic/advtim_pkg.sv ====
//==========================================================================
// advanced timer package
// shared value types, configuration and status structs, timer state enum
//==========================================================================

`include "advtim_params.svh"

package advtim_pkg;

	// counter, compare, prescaler and repetition values
	typedef logic [`ADVTIM_CNT_W-1:0] cnt_t;

	// output compare mode
	typedef logic [2:0] oc_mode_t;

	// one bit per interrupt source
	typedef logic [`ADVTIM_INT_NUM-1:0] int_vec_t;

	// counter configuration, shadow copy
	typedef struct packed {
		cnt_t		psc;
		cnt_t		arr;
		cnt_t		rcr;
		// 1 counts down
		logic		dir;
	} tim_cfg_t;

	// channel configuration
	// field order matches the CHx register layout, bit 20 down to bit 0
	typedef struct packed {
		logic		en;
		logic		pol;
		oc_mode_t	mode;
		cnt_t		ccr;
	} ch_cfg_t;

	// counter outputs
	typedef struct packed {
		cnt_t		cnt;
		logic		running;
		logic		reload;
		logic		tim_end;
	} tim_stat_t;

	typedef enum logic {
		TIM_IDLE,
		TIM_RUN
	} tim_state_e;

endpackage

// ==== logic/advtim_regs.sv ====
//==========================================================================
// advanced timer register file
// APB decode into preload registers and control strobes, shadow copies
// refreshed on the timer's hardware update event, and the read mux
//==========================================================================

`timescale 1ns/10ps

`include "advtim_params.svh"

module advtim_regs
(
	input  logic						module_clk,
	input  logic						module_rstn,

	// APB slave
	input  logic						psel,
	input  logic						penable,
	input  logic						pwrite,
	input  logic [`ADVTIM_ADDR_W-1:0]	paddr,
	input  logic [`ADVTIM_DATA_W-1:0]	pwdata,
	output logic [`ADVTIM_DATA_W-1:0]	prdata,

	// counter control
	output logic						start,
	output logic						logic_clr,
	input  logic						hw_update,
	output advtim_pkg::tim_cfg_t		tim_cfg,
	output advtim_pkg::ch_cfg_t			ch1_cfg,
	output advtim_pkg::ch_cfg_t			ch2_cfg,
	input  advtim_pkg::tim_stat_t		stat,

	// interrupt control
	output advtim_pkg::int_vec_t		int_en,
	output advtim_pkg::int_vec_t		int_clr,
	input  advtim_pkg::int_vec_t		int_sta
);

	logic						wr_en;
	logic						wr_ctrl;
	advtim_pkg::cnt_t			psc_pre;
	advtim_pkg::cnt_t			arr_pre;
	advtim_pkg::cnt_t			rcr_pre;
	logic						dir_pre;
	advtim_pkg::ch_cfg_t		ch1_pre;
	advtim_pkg::ch_cfg_t		ch2_pre;

	assign wr_en = psel && penable && pwrite;
	assign wr_ctrl = wr_en && (paddr == `ADVTIM_REG_CTRL);

	//==========================================================================
	// preload registers
	//==========================================================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			psc_pre <= '0;
			arr_pre <= '0;
			rcr_pre <= '0;
			dir_pre <= 1'b0;
			ch1_pre <= '0;
			ch2_pre <= '0;
			int_en <= '0;
		end
		else if (wr_en)
		begin
			case (paddr)
				`ADVTIM_REG_CTRL:	dir_pre <= pwdata[2];
				`ADVTIM_REG_PSC:	psc_pre <= pwdata[`ADVTIM_CNT_W-1:0];
				`ADVTIM_REG_ARR:	arr_pre <= pwdata[`ADVTIM_CNT_W-1:0];
				`ADVTIM_REG_RCR:	rcr_pre <= pwdata[`ADVTIM_CNT_W-1:0];
				`ADVTIM_REG_CH1:	ch1_pre <= advtim_pkg::ch_cfg_t'(pwdata[20:0]);
				`ADVTIM_REG_CH2:	ch2_pre <= advtim_pkg::ch_cfg_t'(pwdata[20:0]);
				`ADVTIM_REG_INT_EN:	int_en <= pwdata[`ADVTIM_INT_NUM-1:0];
				default:			;
			endcase
		end
	end

	// control strobes, one cycle after the write edge
	// logic clear takes priority when both bits are written
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			start <= 1'b0;
			logic_clr <= 1'b0;
			int_clr <= '0;
		end
		else
		begin
			start <= wr_ctrl && pwdata[0] && !pwdata[1];
			logic_clr <= wr_ctrl && pwdata[1];
			if (wr_en && (paddr == `ADVTIM_REG_INT_STA))
				int_clr <= pwdata[`ADVTIM_INT_NUM-1:0];
			else
				int_clr <= '0;
		end
	end

	//==========================================================================
	// shadow registers
	//==========================================================================

	// hw_update is the start pulse or a counter reload
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			tim_cfg <= '0;
			ch1_cfg <= '0;
			ch2_cfg <= '0;
		end
		else if (hw_update)
		begin
			tim_cfg.psc <= psc_pre;
			tim_cfg.arr <= arr_pre;
			tim_cfg.rcr <= rcr_pre;
			tim_cfg.dir <= dir_pre;
			ch1_cfg <= ch1_pre;
			ch2_cfg <= ch2_pre;
		end
	end

	// read mux, preloads and live status
	always_comb
	begin
		prdata = '0;
		case (paddr)
			`ADVTIM_REG_CTRL:		prdata[2] = dir_pre;
			`ADVTIM_REG_PSC:		prdata[`ADVTIM_CNT_W-1:0] = psc_pre;
			`ADVTIM_REG_ARR:		prdata[`ADVTIM_CNT_W-1:0] = arr_pre;
			`ADVTIM_REG_RCR:		prdata[`ADVTIM_CNT_W-1:0] = rcr_pre;
			`ADVTIM_REG_CH1:		prdata[20:0] = ch1_pre;
			`ADVTIM_REG_CH2:		prdata[20:0] = ch2_pre;
			`ADVTIM_REG_INT_EN:		prdata[`ADVTIM_INT_NUM-1:0] = int_en;
			`ADVTIM_REG_INT_STA:	prdata[`ADVTIM_INT_NUM-1:0] = int_sta;
			`ADVTIM_REG_STAT:
			begin
				prdata[`ADVTIM_CNT_W-1:0] = stat.cnt;
				prdata[16] = stat.running;
			end
			default:				prdata = '0;
		endcase
	end

	// a logic clear always leaves the counter idle
	a_clr_stops: assert property (@(posedge module_clk) disable iff (!module_rstn)
		logic_clr |=> !stat.running);

endmodule

// ==== logic/advtim_counter.sv ====
//==========================================================================
// advanced timer counter core
// enable FSM, prescaler, up/down counter and repetition counter
//==========================================================================

`timescale 1ns/10ps

module advtim_counter
(
	input  logic					module_clk,
	input  logic					module_rstn,
	input  logic					start,
	input  logic					logic_clr,
	input  advtim_pkg::tim_cfg_t	tim_cfg,
	output advtim_pkg::tim_stat_t	stat,
	output logic					hw_update
);

	advtim_pkg::tim_state_e		state;
	advtim_pkg::cnt_t			psc_cnt;
	advtim_pkg::cnt_t			up_cnt;
	advtim_pkg::cnt_t			rep_cnt;
	logic						running;
	logic						start_ok;
	logic						step;
	logic						wrap;
	logic						last_period;

	assign running = (state == advtim_pkg::TIM_RUN);
	// start while running is ignored
	assign start_ok = start && !running;
	assign step = running && !logic_clr && (psc_cnt == tim_cfg.psc);
	assign wrap = step && (up_cnt == tim_cfg.arr);
	// >= covers an rcr lowered by a preload mid-run
	assign last_period = (rep_cnt >= tim_cfg.rcr);

	//==========================================================================
	// enable FSM and counters
	//==========================================================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			state <= advtim_pkg::TIM_IDLE;
			psc_cnt <= '0;
			up_cnt <= '0;
			rep_cnt <= '0;
		end
		else if (logic_clr || start_ok)
		begin
			state <= logic_clr ? advtim_pkg::TIM_IDLE : advtim_pkg::TIM_RUN;
			psc_cnt <= '0;
			up_cnt <= '0;
			rep_cnt <= '0;
		end
		else if (running)
		begin
			if (step)
				psc_cnt <= '0;
			else
				psc_cnt <= psc_cnt + 1'b1;

			if (wrap)
			begin
				up_cnt <= '0;
				if (last_period)
				begin
					state <= advtim_pkg::TIM_IDLE;
					rep_cnt <= '0;
				end
				else
					rep_cnt <= rep_cnt + 1'b1;
			end
			else if (step)
				up_cnt <= up_cnt + 1'b1;
		end
	end

	// counter always runs upward inside; down mode mirrors it against arr
	// so the first down value is the freshly loaded arr
	always_comb
	begin
		if (!running)
			stat.cnt = '0;
		else if (tim_cfg.dir)
			stat.cnt = tim_cfg.arr - up_cnt;
		else
			stat.cnt = up_cnt;
	end

	assign stat.running = running;
	assign stat.reload = wrap && !last_period;
	assign stat.tim_end = wrap && last_period;

	// shadows load on start and at every period boundary
	assign hw_update = start_ok || stat.reload;

	// the last wrap always ends the run
	a_end_idle: assert property (@(posedge module_clk) disable iff (!module_rstn)
		stat.tim_end |=> !stat.running);

	a_cnt_in_range: assert property (@(posedge module_clk) disable iff (!module_rstn)
		stat.running |-> (stat.cnt <= tim_cfg.arr));

endmodule

// ==== logic/advtim_pwm_channel.sv ====
//==========================================================================
// PWM compare channel
// compares the counter against ccr and drives the output level
//==========================================================================

`timescale 1ns/10ps

`include "advtim_params.svh"

module advtim_pwm_channel
(
	input  logic					module_clk,
	input  logic					module_rstn,
	input  advtim_pkg::ch_cfg_t		cfg,
	input  advtim_pkg::cnt_t		cnt,
	input  logic					running,
	output logic					pwm
);

	logic		active;

	// active level before polarity
	always_comb
	begin
		case (cfg.mode)
			`ADVTIM_OC_FRZ_LO:	active = 1'b0;
			`ADVTIM_OC_FRZ_HI:	active = 1'b1;
			`ADVTIM_OC_PWM1:	active = (cnt < cfg.ccr);
			`ADVTIM_OC_PWM2:	active = (cnt >= cfg.ccr);
			default:			active = 1'b0;
		endcase
	end

	// idle or disabled channel sits at the inactive level
	assign pwm = (cfg.en && running && active) ^ cfg.pol;

endmodule

// ==== logic/advtim_int_ctrl.sv ====
//==========================================================================
// interrupt control
// sticky status per source, W1C clear, enable mask, registered int line
//==========================================================================

`timescale 1ns/10ps

module advtim_int_ctrl
(
	input  logic					module_clk,
	input  logic					module_rstn,
	input  advtim_pkg::int_vec_t	int_tgr,
	input  advtim_pkg::int_vec_t	int_en,
	input  advtim_pkg::int_vec_t	int_clr,
	output advtim_pkg::int_vec_t	int_sta,
	output logic					int_line
);

	// set wins over a clear in the same cycle
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			int_sta <= '0;
		else
			int_sta <= (int_sta & ~int_clr) | int_tgr;
	end

	// line follows masked status by one cycle
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			int_line <= 1'b0;
		else
			int_line <= |(int_sta & int_en);
	end

	// W1C clears arrive as single-cycle pulses
	a_clr_pulse: assert property (@(posedge module_clk) disable iff (!module_rstn)
		(int_clr != '0) |=> (int_clr == '0));

endmodule

// ==== logic/advtim_top.sv ====
//==========================================================================
// advanced timer top
// register file, counter core, two PWM channels and interrupt control
//==========================================================================

`timescale 1ns/10ps

`include "advtim_params.svh"

module advtim_top
(
	input  logic						module_clk,
	input  logic						module_rstn,

	// APB slave
	input  logic						psel,
	input  logic						penable,
	input  logic						pwrite,
	input  logic [`ADVTIM_ADDR_W-1:0]	paddr,
	input  logic [`ADVTIM_DATA_W-1:0]	pwdata,
	output logic [`ADVTIM_DATA_W-1:0]	prdata,

	output logic						pwm1,
	output logic						pwm2,
	output logic						int_line
);

	logic						start;
	logic						logic_clr;
	logic						hw_update;
	advtim_pkg::tim_cfg_t		tim_cfg;
	advtim_pkg::ch_cfg_t		ch1_cfg;
	advtim_pkg::ch_cfg_t		ch2_cfg;
	advtim_pkg::tim_stat_t		stat;
	advtim_pkg::int_vec_t		int_en;
	advtim_pkg::int_vec_t		int_clr;
	advtim_pkg::int_vec_t		int_sta;
	advtim_pkg::int_vec_t		int_tgr;

	// counter events are already single-cycle pulses
	assign int_tgr[`ADVTIM_INT_RELOAD] = stat.reload;
	assign int_tgr[`ADVTIM_INT_END] = stat.tim_end;

	//==========================================================================
	// registers and counter
	//==========================================================================

	advtim_regs u_regs
	(
		.module_clk		(module_clk),
		.module_rstn	(module_rstn),
		.psel			(psel),
		.penable		(penable),
		.pwrite			(pwrite),
		.paddr			(paddr),
		.pwdata			(pwdata),
		.prdata			(prdata),
		.start			(start),
		.logic_clr		(logic_clr),
		.hw_update		(hw_update),
		.tim_cfg		(tim_cfg),
		.ch1_cfg		(ch1_cfg),
		.ch2_cfg		(ch2_cfg),
		.stat			(stat),
		.int_en			(int_en),
		.int_clr		(int_clr),
		.int_sta		(int_sta)
	);

	advtim_counter u_counter
	(
		.module_clk		(module_clk),
		.module_rstn	(module_rstn),
		.start			(start),
		.logic_clr		(logic_clr),
		.tim_cfg		(tim_cfg),
		.stat			(stat),
		.hw_update		(hw_update)
	);

	//==========================================================================
	// outputs
	//==========================================================================

	advtim_pwm_channel u_ch1
	(
		.module_clk		(module_clk),
		.module_rstn	(module_rstn),
		.cfg			(ch1_cfg),
		.cnt			(stat.cnt),
		.running		(stat.running),
		.pwm			(pwm1)
	);

	advtim_pwm_channel u_ch2
	(
		.module_clk		(module_clk),
		.module_rstn	(module_rstn),
		.cfg			(ch2_cfg),
		.cnt			(stat.cnt),
		.running		(stat.running),
		.pwm			(pwm2)
	);

	advtim_int_ctrl u_int
	(
		.module_clk		(module_clk),
		.module_rstn	(module_rstn),
		.int_tgr		(int_tgr),
		.int_en			(int_en),
		.int_clr		(int_clr),
		.int_sta		(int_sta),
		.int_line		(int_line)
	);

endmodule

// ==== verif/advtim_tb.sv ====
//==========================================================================
// advanced timer testbench
// APB driver, output monitor, reference model of the counter timing,
// and directed runs with random timer settings
//==========================================================================

`timescale 1ns/10ps

`include "advtim_params.svh"

module advtim_tb;

	localparam int CLK_PERIOD = 100;
	// worst case run is (3+1)(20+1)(3+1) cycles, about six runs in total
	localparam int WORST_RUN = 336;
	localparam int WATCHDOG_CYCLES = 6 * WORST_RUN * 4 + 2000;

	logic							module_clk;
	logic							module_rstn;
	logic							psel;
	logic							penable;
	logic							pwrite;
	logic [`ADVTIM_ADDR_W-1:0]		paddr;
	logic [`ADVTIM_DATA_W-1:0]		pwdata;
	logic [`ADVTIM_DATA_W-1:0]		prdata;
	logic							pwm1;
	logic							pwm2;
	logic							int_line;

	int		errors;
	int		checks;
	int		tests;
	int		err_start;
	int		n_run;
	int		n_p2hi;
	int		n_p2lo;
	int		n_irq;
	int		psc;
	int		arr;
	int		rcr;
	int		ccr;
	int		arr1;
	logic [31:0]	rdata;
	logic			first_p2;

	advtim_top u_advtim_top
	(
		.module_clk		(module_clk),
		.module_rstn	(module_rstn),
		.psel			(psel),
		.penable		(penable),
		.pwrite			(pwrite),
		.paddr			(paddr),
		.pwdata			(pwdata),
		.prdata			(prdata),
		.pwm1			(pwm1),
		.pwm2			(pwm2),
		.int_line		(int_line)
	);

	initial
	begin
		module_clk = 1'b0;
		forever #(CLK_PERIOD / 2) module_clk = ~module_clk;
	end

	// pwm1 is set up to be active for the whole run, so it marks running
	always @(posedge module_clk)
	begin
		// pwm2 level in the first cycle of a run
		if (pwm1 && n_run == 0)
			first_p2 = pwm2;
		if (pwm1)
			n_run++;
		if (pwm1 && pwm2)
			n_p2hi++;
		if (pwm1 && !pwm2)
			n_p2lo++;
		if (int_line)
			n_irq++;
	end

	//==========================================================================
	// reference model
	//==========================================================================

	function automatic int run_length(input int p, input int a, input int r);
		return (p + 1) * (a + 1) * (r + 1);
	endfunction

	// cycles of a run in which the channel is active, before polarity
	function automatic int active_cycles(input int p, input int a, input int r,
		input int c, input logic [2:0] mode);
		int per_period;
		per_period = 0;
		for (int v = 0; v <= a; v++)
		begin
			if (mode == `ADVTIM_OC_PWM1 && v < c)
				per_period++;
			else if (mode == `ADVTIM_OC_PWM2 && v >= c)
				per_period++;
			else if (mode == `ADVTIM_OC_FRZ_HI)
				per_period++;
		end
		return per_period * (p + 1) * (r + 1);
	endfunction

	//==========================================================================
	// APB driver and checks
	//==========================================================================

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge module_clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge module_clk);
		penable = 1'b1;
		@(negedge module_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// prdata is sampled in the access phase, paddr is stable since setup
	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge module_clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge module_clk);
		penable = 1'b1;
		data = prdata;
		@(negedge module_clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge module_clk);
	endtask

	task automatic write_read_check(input logic [7:0] addr, input logic [31:0] value,
		input string name);
		logic [31:0] got;
		apb_write(addr, value);
		apb_read(addr, got);
		check_value(name, value, got);
	endtask

	task automatic set_channel(input logic [7:0] addr, input logic pol,
		input logic [2:0] mode, input int c);
		apb_write(addr, {11'd0, 1'b1, pol, mode, c[15:0]});
	endtask

	// timer settings plus channel 1 active for the whole run
	task automatic program_timer(input int p, input int a, input int r);
		apb_write(`ADVTIM_REG_PSC, p);
		apb_write(`ADVTIM_REG_ARR, a);
		apb_write(`ADVTIM_REG_RCR, r);
		set_channel(`ADVTIM_REG_CH1, 1'b0, `ADVTIM_OC_PWM1, a + 1);
	endtask

	task automatic wait_run_end(input int limit);
		int n;
		n = 0;
		while (!pwm1 && n < limit)
		begin
			@(negedge module_clk);
			n++;
		end
		while (pwm1 && n < limit)
		begin
			@(negedge module_clk);
			n++;
		end
		if (n >= limit)
		begin
			$display("timer run did not finish within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic clear_counts();
		@(negedge module_clk);
		n_run = 0;
		n_p2hi = 0;
		n_p2lo = 0;
		n_irq = 0;
	endtask

	task automatic run_timer(input logic [31:0] ctrl);
		clear_counts();
		apb_write(`ADVTIM_REG_CTRL, ctrl);
		wait_run_end(2 * WORST_RUN + 50);
	endtask

	task automatic begin_test();
		err_start = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "errors");
	endtask

	task automatic random_settings();
		psc = $urandom_range(3, 0);
		arr = $urandom_range(20, 3);
		rcr = $urandom_range(3, 0);
		ccr = $urandom_range(arr + 1, 0);
	endtask

	//==========================================================================
	// tests
	//==========================================================================

	initial
	begin
		errors = 0;
		checks = 0;
		tests = 0;
		module_rstn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		void'($urandom(32'hb2a9_9ffa));
		repeat (10) @(posedge module_clk);
		@(negedge module_clk);
		module_rstn = 1'b1;

		begin_test();
		apb_read(`ADVTIM_REG_STAT, rdata);
		check_value("stat after reset", 32'h0, rdata);
		write_read_check(`ADVTIM_REG_PSC, $urandom & 32'hffff, "psc");
		write_read_check(`ADVTIM_REG_ARR, $urandom & 32'hffff, "arr");
		write_read_check(`ADVTIM_REG_RCR, $urandom & 32'hffff, "rcr");
		write_read_check(`ADVTIM_REG_CH1, $urandom & 32'h1f_ffff, "ch1");
		write_read_check(`ADVTIM_REG_CH2, $urandom & 32'h1f_ffff, "ch2");
		write_read_check(`ADVTIM_REG_INT_EN, $urandom & 32'h3, "int_en");
		end_test("register read-back");

		begin_test();
		random_settings();
		program_timer(psc, arr, rcr);
		set_channel(`ADVTIM_REG_CH2, 1'b0, `ADVTIM_OC_PWM1, ccr);
		run_timer(32'h1);
		check_value("pwm1 high cycles", run_length(psc, arr, rcr), n_run);
		check_value("pwm2 high cycles",
			active_cycles(psc, arr, rcr, ccr, `ADVTIM_OC_PWM1), n_p2hi);
		apb_read(`ADVTIM_REG_STAT, rdata);
		check_value("stat running", 32'h0, rdata[16]);
		end_test("up count pwm1");

		begin_test();
		random_settings();
		// compare inside the period so the first down value is active
		ccr = $urandom_range(arr, 1);
		program_timer(psc, arr, rcr);
		set_channel(`ADVTIM_REG_CH2, 1'b1, `ADVTIM_OC_PWM2, ccr);
		// start with direction down
		run_timer(32'h5);
		check_value("pwm1 high cycles", run_length(psc, arr, rcr), n_run);
		check_value("pwm2 low cycles",
			active_cycles(psc, arr, rcr, ccr, `ADVTIM_OC_PWM2), n_p2lo);
		// down count starts at arr
		check_value("pwm2 first cycle", (arr >= ccr) ? 32'h0 : 32'h1, first_p2);
		check_value("pwm2 after run", 32'h1, pwm2);
		end_test("down count pwm2 inverted");

		begin_test();
		random_settings();
		rcr = $urandom_range(3, 1);
		program_timer(psc, arr, rcr);
		apb_write(`ADVTIM_REG_INT_EN, 32'h3);
		apb_write(`ADVTIM_REG_INT_STA, 32'h3);
		run_timer(32'h1);
		idle(2);
		apb_read(`ADVTIM_REG_INT_STA, rdata);
		check_value("int_sta", 32'h3, rdata);
		check_value("int_line", 32'h1, int_line);
		apb_write(`ADVTIM_REG_INT_STA, 32'h1);
		idle(2);
		apb_read(`ADVTIM_REG_INT_STA, rdata);
		check_value("int_sta", 32'h2, rdata);
		apb_write(`ADVTIM_REG_INT_STA, 32'h3);
		idle(3);
		apb_read(`ADVTIM_REG_INT_STA, rdata);
		check_value("int_sta", 32'h0, rdata);
		check_value("int_line", 32'h0, int_line);
		// masked sources must keep the line low for a whole run
		apb_write(`ADVTIM_REG_INT_EN, 32'h0);
		run_timer(32'h1);
		idle(3);
		check_value("int_line high cycles", 32'h0, n_irq);
		check_value("int_line", 32'h0, int_line);
		end_test("interrupts");

		begin_test();
		psc = 0;
		arr = $urandom_range(20, 10);
		arr1 = $urandom_range(20, 3);
		rcr = $urandom_range(3, 1);
		program_timer(psc, arr, rcr);
		// channel 1 compare above both reload values
		set_channel(`ADVTIM_REG_CH1, 1'b0, `ADVTIM_OC_PWM1, 16'hffff);
		clear_counts();
		apb_write(`ADVTIM_REG_CTRL, 32'h1);
		apb_write(`ADVTIM_REG_ARR, arr1);
		wait_run_end(2 * WORST_RUN + 50);
		check_value("pwm1 high cycles",
			run_length(0, arr, 0) + run_length(0, arr1, rcr - 1), n_run);
		end_test("preload");

		begin_test();
		program_timer(3, 20, 3);
		apb_write(`ADVTIM_REG_INT_STA, 32'h3);
		apb_write(`ADVTIM_REG_CTRL, 32'h1);
		idle(10);
		check_value("pwm1 in run", 32'h1, pwm1);
		apb_write(`ADVTIM_REG_CTRL, 32'h2);
		idle(2);
		check_value("pwm1 after clear", 32'h0, pwm1);
		apb_read(`ADVTIM_REG_STAT, rdata);
		check_value("stat running", 32'h0, rdata[16]);
		apb_read(`ADVTIM_REG_INT_STA, rdata);
		check_value("int_sta end bit", 32'h0, rdata[`ADVTIM_INT_END]);
		end_test("logic clear");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
logic/advtim_pkg.sv
logic/advtim_regs.sv
logic/advtim_counter.sv
logic/advtim_pwm_channel.sv
logic/advtim_int_ctrl.sv
logic/advtim_top.sv
verif/advtim_tb.sv

// ==== Makefile ====
# Verilator build and run for the advanced timer testbench

VERILATOR ?= verilator
TOP       ?= advtim_tb
SEED      ?= 1
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_TEXT := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP SEED FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
